/* rtl/ant_macros.svh */
`ifndef ANT_MACROS_SVH
`define ANT_MACROS_SVH

// Datapath field widths
`define X_COORD_WIDTH   8
`define Y_COORD_WIDTH   7
`define COLOUR_WIDTH    3
`define MEM_ADDR_WIDTH  8
`define RESULT_WIDTH    16

// Visible screen area in pixels
`define SCREEN_WIDTH    160
`define SCREEN_HEIGHT   120

// Ant sprite size centred on the stored coordinate
`define ANT_WIDTH       3
`define ANT_HEIGHT      3

// Coordinate tables in datapath memory indexed by ant id
`define ANT_X_BASE      8'h00
`define ANT_Y_BASE      8'h40

// Sprite colour
`define COLOUR_ANT      3'b010

`endif

/* rtl/ant_pkg.sv */
`include "ant_macros.svh"

package ant_pkg;

    typedef logic [`X_COORD_WIDTH-1:0]  x_coord_t;
    typedef logic [`Y_COORD_WIDTH-1:0]  y_coord_t;
    typedef logic [`COLOUR_WIDTH-1:0]   colour_t;
    typedef logic [`MEM_ADDR_WIDTH-1:0] mem_addr_t;
    typedef logic [`RESULT_WIDTH-1:0]   result_t;

    // Datapath operations
    typedef enum logic [1:0] {
        OP_NONE,
        OP_MEMREAD,
        OP_MEMWRITE,
        OP_DRAW
    } opcode_t;

    typedef struct packed {
        logic     plot;
        colour_t  colour;
        x_coord_t x;
        y_coord_t y;
    } pixel_t;

    // Fields not used by the opcode are left at zero
    typedef struct packed {
        opcode_t   opcode;
        mem_addr_t addr;
        result_t   data;
        pixel_t    pixel;
    } dp_command_t;

    typedef struct packed {
        logic left;
        logic right;
        logic up;
        logic down;
    } move_t;

    function automatic mem_addr_t ant_x_addr(input mem_addr_t id);
        return `ANT_X_BASE + id;
    endfunction

    function automatic mem_addr_t ant_y_addr(input mem_addr_t id);
        return `ANT_Y_BASE + id;
    endfunction

endpackage

/* rtl/dp_issuer.sv */
module dp_issuer (
    input  logic                 clock,
    input  logic                 resetn,
    input  logic                 request,
    input  ant_pkg::dp_command_t command,
    input  logic                 finished_dp,
    input  ant_pkg::result_t     result_dp,
    output logic                 start_dp,
    output ant_pkg::dp_command_t instruction_dp,
    output logic                 done,
    output ant_pkg::result_t     result
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_STROBE,
        ST_WAIT
    } issuer_state_t;

    issuer_state_t state;
    // Set once the first strobe cycle has passed
    logic          strobe_cnt;

    always_ff @(posedge clock) begin
        if (!resetn) begin
            state          <= ST_IDLE;
            strobe_cnt     <= 1'b0;
            start_dp       <= 1'b0;
            instruction_dp <= '0;
            done           <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (request) begin
                        // Command is held until the datapath finishes
                        instruction_dp <= command;
                        start_dp       <= 1'b1;
                        strobe_cnt     <= 1'b0;
                        state          <= ST_STROBE;
                    end
                end
                ST_STROBE: begin
                    if (strobe_cnt) begin
                        start_dp <= 1'b0;
                        state    <= ST_WAIT;
                    end else begin
                        strobe_cnt <= 1'b1;
                    end
                end
                ST_WAIT: begin
                    // finished_dp only counts once start_dp has dropped
                    if (finished_dp) begin
                        done  <= 1'b1;
                        state <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (state == ST_WAIT && finished_dp) begin
            result <= result_dp;
        end
    end

    // Sequencers must wait for done before the next request
    a_request_in_idle: assert property (@(posedge clock) disable iff (!resetn)
        request |-> state == ST_IDLE);

    a_strobe_two_cycles: assert property (@(posedge clock) disable iff (!resetn)
        start_dp [*2] |=> !start_dp);

endmodule

/* rtl/ant_draw.sv */
`include "ant_macros.svh"

module ant_draw (
    input  logic                 clock,
    input  logic                 resetn,
    input  logic                 start,
    input  ant_pkg::mem_addr_t   id,
    output logic                 request,
    output ant_pkg::dp_command_t command,
    input  logic                 done,
    input  ant_pkg::result_t     result,
    output logic                 job_done
);

    import ant_pkg::*;

    typedef enum logic [2:0] {
        S_IDLE,
        S_WAIT_X,
        S_WAIT_Y,
        S_DRAW,
        S_WAIT_PIX
    } draw_state_t;

    localparam x_coord_t DX_LAST = x_coord_t'(`ANT_WIDTH - 1);
    localparam y_coord_t DY_LAST = y_coord_t'(`ANT_HEIGHT - 1);

    draw_state_t state;

    // Top-left corner of the sprite and offset of the current pixel
    x_coord_t corner_x;
    y_coord_t corner_y;
    x_coord_t dx;
    y_coord_t dy;

    always_ff @(posedge clock) begin
        if (!resetn) begin
            state    <= S_IDLE;
            request  <= 1'b0;
            job_done <= 1'b0;
            dx       <= '0;
            dy       <= '0;
        end else begin
            request  <= 1'b0;
            job_done <= 1'b0;
            case (state)
                S_IDLE: begin
                    if (start) begin
                        dx      <= '0;
                        dy      <= '0;
                        request <= 1'b1;
                        command <= '{opcode: OP_MEMREAD, addr: ant_x_addr(id),
                                     data: '0, pixel: '0};
                        state   <= S_WAIT_X;
                    end
                end
                S_WAIT_X: begin
                    if (done) begin
                        corner_x <= x_coord_t'(result) - x_coord_t'(1);
                        request  <= 1'b1;
                        command  <= '{opcode: OP_MEMREAD, addr: ant_y_addr(id),
                                      data: '0, pixel: '0};
                        state    <= S_WAIT_Y;
                    end
                end
                S_WAIT_Y: begin
                    if (done) begin
                        corner_y <= y_coord_t'(result) - y_coord_t'(1);
                        state    <= S_DRAW;
                    end
                end
                S_DRAW: begin
                    request <= 1'b1;
                    command <= '{opcode: OP_DRAW, addr: '0, data: '0,
                                 pixel: '{plot: 1'b1, colour: `COLOUR_ANT,
                                          x: corner_x + dx, y: corner_y + dy}};
                    state   <= S_WAIT_PIX;
                end
                S_WAIT_PIX: begin
                    if (done) begin
                        // Walk along the row first, then step down
                        if (dx == DX_LAST) begin
                            dx <= '0;
                            if (dy == DY_LAST) begin
                                dy       <= '0;
                                job_done <= 1'b1;
                                state    <= S_IDLE;
                            end else begin
                                dy    <= dy + y_coord_t'(1);
                                state <= S_DRAW;
                            end
                        end else begin
                            dx    <= dx + x_coord_t'(1);
                            state <= S_DRAW;
                        end
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    a_dx_in_sprite: assert property (@(posedge clock) disable iff (!resetn)
        dx < `ANT_WIDTH);

endmodule

/* rtl/ant_update.sv */
`include "ant_macros.svh"

module ant_update (
    input  logic                 clock,
    input  logic                 resetn,
    input  logic                 start,
    input  ant_pkg::mem_addr_t   id,
    input  ant_pkg::move_t       move,
    output logic                 request,
    output ant_pkg::dp_command_t command,
    input  logic                 done,
    input  ant_pkg::result_t     result,
    output logic                 job_done
);

    import ant_pkg::*;

    typedef enum logic [2:0] {
        S_IDLE,
        S_WAIT_X,
        S_WAIT_Y,
        S_MOVE,
        S_WAIT_WX,
        S_WAIT_WY
    } update_state_t;

    // Margins keep the whole sprite on screen
    localparam x_coord_t X_LOW  = x_coord_t'(`ANT_WIDTH / 2);
    localparam x_coord_t X_HIGH = x_coord_t'(`SCREEN_WIDTH - (`ANT_WIDTH / 2) - 1);
    localparam y_coord_t Y_LOW  = y_coord_t'(`ANT_HEIGHT / 2);
    localparam y_coord_t Y_HIGH = y_coord_t'(`SCREEN_HEIGHT - (`ANT_HEIGHT / 2) - 1);

    update_state_t state;

    move_t    move_q;
    x_coord_t x;
    y_coord_t y;
    x_coord_t x_next;
    y_coord_t y_next;

    // Each test sees the value left by the one before it
    always_comb begin
        x_next = x;
        if (move_q.left && x_next > X_LOW) begin
            x_next = x_next - x_coord_t'(1);
        end
        if (move_q.right && x_next < X_HIGH) begin
            x_next = x_next + x_coord_t'(1);
        end
        y_next = y;
        if (move_q.up && y_next > Y_LOW) begin
            y_next = y_next - y_coord_t'(1);
        end
        if (move_q.down && y_next < Y_HIGH) begin
            y_next = y_next + y_coord_t'(1);
        end
    end

    always_ff @(posedge clock) begin
        if (!resetn) begin
            state    <= S_IDLE;
            request  <= 1'b0;
            job_done <= 1'b0;
        end else begin
            request  <= 1'b0;
            job_done <= 1'b0;
            case (state)
                S_IDLE: begin
                    if (start) begin
                        move_q  <= move;
                        request <= 1'b1;
                        command <= '{opcode: OP_MEMREAD, addr: ant_x_addr(id),
                                     data: '0, pixel: '0};
                        state   <= S_WAIT_X;
                    end
                end
                S_WAIT_X: begin
                    if (done) begin
                        x       <= x_coord_t'(result);
                        request <= 1'b1;
                        command <= '{opcode: OP_MEMREAD, addr: ant_y_addr(id),
                                     data: '0, pixel: '0};
                        state   <= S_WAIT_Y;
                    end
                end
                S_WAIT_Y: begin
                    if (done) begin
                        y     <= y_coord_t'(result);
                        state <= S_MOVE;
                    end
                end
                S_MOVE: begin
                    x       <= x_next;
                    y       <= y_next;
                    request <= 1'b1;
                    command <= '{opcode: OP_MEMWRITE, addr: ant_x_addr(id),
                                 data: result_t'(x_next), pixel: '0};
                    state   <= S_WAIT_WX;
                end
                S_WAIT_WX: begin
                    if (done) begin
                        request <= 1'b1;
                        command <= '{opcode: OP_MEMWRITE, addr: ant_y_addr(id),
                                     data: result_t'(y), pixel: '0};
                        state   <= S_WAIT_WY;
                    end
                end
                S_WAIT_WY: begin
                    if (done) begin
                        job_done <= 1'b1;
                        state    <= S_IDLE;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    a_x_on_screen: assert property (@(posedge clock) disable iff (!resetn)
        request && command.opcode == OP_MEMWRITE && command.addr == ant_x_addr(id)
        |-> command.data < `SCREEN_WIDTH);

endmodule

/* rtl/ant_engine.sv */
module ant_engine (
    input  logic                 clock,
    input  logic                 resetn,
    input  logic                 start_draw,
    input  logic                 start_update,
    input  ant_pkg::mem_addr_t   id,
    input  ant_pkg::move_t       move,
    output logic                 busy,
    output logic                 start_dp,
    output ant_pkg::dp_command_t instruction_dp,
    input  logic                 finished_dp,
    input  ant_pkg::result_t     result_dp
);

    import ant_pkg::*;

    logic        accept_draw;
    logic        accept_update;
    logic        draw_go;
    logic        update_go;
    // High while the update job owns the issuer
    logic        grant_update;
    mem_addr_t   id_q;
    move_t       move_q;

    logic        draw_request;
    dp_command_t draw_command;
    logic        draw_job_done;
    logic        update_request;
    dp_command_t update_command;
    logic        update_job_done;

    logic        issue_request;
    dp_command_t issue_command;
    logic        issue_done;
    result_t     issue_result;

    // Update wins when both starts arrive together
    assign accept_update = start_update && !busy;
    assign accept_draw   = start_draw && !start_update && !busy;

    always_ff @(posedge clock) begin
        if (!resetn) begin
            busy         <= 1'b0;
            grant_update <= 1'b0;
            draw_go      <= 1'b0;
            update_go    <= 1'b0;
        end else begin
            draw_go   <= accept_draw;
            update_go <= accept_update;
            if (accept_update || accept_draw) begin
                busy         <= 1'b1;
                grant_update <= accept_update;
            end else if (draw_job_done || update_job_done) begin
                busy <= 1'b0;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (accept_update || accept_draw) begin
            id_q   <= id;
            move_q <= move;
        end
    end

    assign issue_request = grant_update ? update_request : draw_request;
    assign issue_command = grant_update ? update_command : draw_command;

    dp_issuer issuer (
        .clock          (clock),
        .resetn         (resetn),
        .request        (issue_request),
        .command        (issue_command),
        .finished_dp    (finished_dp),
        .result_dp      (result_dp),
        .start_dp       (start_dp),
        .instruction_dp (instruction_dp),
        .done           (issue_done),
        .result         (issue_result)
    );

    ant_draw draw (
        .clock    (clock),
        .resetn   (resetn),
        .start    (draw_go),
        .id       (id_q),
        .request  (draw_request),
        .command  (draw_command),
        .done     (issue_done && !grant_update),
        .result   (issue_result),
        .job_done (draw_job_done)
    );

    ant_update update (
        .clock    (clock),
        .resetn   (resetn),
        .start    (update_go),
        .id       (id_q),
        .move     (move_q),
        .request  (update_request),
        .command  (update_command),
        .done     (issue_done && grant_update),
        .result   (issue_result),
        .job_done (update_job_done)
    );

endmodule

/* tb/ant_engine_tb.sv */
`include "ant_macros.svh"

module ant_engine_tb;

    import ant_pkg::*;

    localparam string TRACE_PATH = "tb/ant_engine_trace.txt";
    localparam int    MEM_WORDS  = 256;
    localparam int    NUM_PIXELS = `ANT_WIDTH * `ANT_HEIGHT;
    // Request, two strobe cycles, up to three delay cycles, finish, done and the next step
    localparam int    CMD_CYCLES = 10;
    // Two reads and every pixel draw, plus start and busy overhead
    localparam int    JOB_CYCLES = (NUM_PIXELS + 2) * CMD_CYCLES + 20;

    typedef struct packed {
        logic [8*24-1:0] name;
        logic [7:0]      op;
        mem_addr_t       id;
        move_t           move;
        result_t         x;
        result_t         y;
        result_t         exp_x;
        result_t         exp_y;
    } trace_entry_t;

    logic        clock;
    logic        resetn;
    logic        start_draw;
    logic        start_update;
    mem_addr_t   id;
    move_t       move;
    logic        busy;
    logic        start_dp;
    dp_command_t instruction_dp;
    logic        finished_dp;
    result_t     result_dp;

    trace_entry_t trace [$];
    result_t      mem [MEM_WORDS];
    pixel_t       pixel_log [$];
    int           write_count;
    int           value_errors;
    int           other_errors;
    int           cycle_count;
    int           cycle_limit;

    // Datapath model state
    logic [31:0] lfsr;
    logic [1:0]  delay_bits;
    int          strobe_len;
    int          delay;
    logic        outstanding;
    dp_command_t held;

    ant_engine uut (
        .clock          (clock),
        .resetn         (resetn),
        .start_draw     (start_draw),
        .start_update   (start_update),
        .id             (id),
        .move           (move),
        .busy           (busy),
        .start_dp       (start_dp),
        .instruction_dp (instruction_dp),
        .finished_dp    (finished_dp),
        .result_dp      (result_dp)
    );

    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;
    end

    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        if (state[0]) begin
            return (state >> 1) ^ 32'h80200003;
        end
        return state >> 1;
    endfunction

    always @(posedge clock) begin
        cycle_count++;
        if (cycle_limit > 0 && cycle_count > cycle_limit) begin
            $display("Timeout after %0d cycles, a job never finished", cycle_count);
            $display("Test FAILED");
            $finish;
        end
    end

    // Datapath model that answers 0 to 3 cycles after start_dp falls
    always @(negedge clock) begin
        finished_dp = 1'b0;
        if (!resetn) begin
            strobe_len  = 0;
            delay       = -1;
            outstanding = 1'b0;
        end else begin
            if (outstanding && strobe_len == 0 && instruction_dp != held) begin
                other_errors++;
                $display("instruction_dp changed while a command was in progress");
            end
            if (start_dp) begin
                if (strobe_len == 0) begin
                    if (outstanding) begin
                        other_errors++;
                        $display("A command started before the previous one finished");
                    end
                    held        = instruction_dp;
                    outstanding = 1'b1;
                end
                strobe_len++;
            end else if (strobe_len != 0) begin
                if (strobe_len != 2) begin
                    other_errors++;
                    $display("start_dp was high for %0d cycles instead of 2", strobe_len);
                end
                strobe_len    = 0;
                lfsr          = lfsr_next(lfsr);
                delay_bits[0] = lfsr[0];
                lfsr          = lfsr_next(lfsr);
                delay_bits[1] = lfsr[0];
                delay         = int'(delay_bits);
            end
            if (outstanding && !start_dp && delay == 0) begin
                finished_dp = 1'b1;
                result_dp   = '0;
                case (held.opcode)
                    OP_MEMREAD:  result_dp = mem[held.addr];
                    OP_MEMWRITE: begin
                        mem[held.addr] = held.data;
                        write_count++;
                    end
                    OP_DRAW:     pixel_log.push_back(held.pixel);
                    default: begin
                        other_errors++;
                        $display("The datapath got a command with no operation");
                    end
                endcase
                outstanding = 1'b0;
                delay       = -1;
            end else if (outstanding && delay > 0) begin
                delay--;
            end
        end
    end

    task automatic load_trace();
        int              fd;
        int              count;
        string           line;
        logic [8*24-1:0] name;
        logic [7:0]      op;
        logic [7:0]      id_v;
        logic [3:0]      move_v;
        int              x_v;
        int              y_v;
        int              ex_v;
        int              ey_v;
        trace_entry_t    entry;
        fd = $fopen(TRACE_PATH, "r");
        if (fd == 0) begin
            other_errors++;
            $display("Cannot open the trace file %0s", TRACE_PATH);
        end else begin
            while ($fgets(line, fd) != 0) begin
                count = $sscanf(line, "%s %s %h %h %d %d %d %d",
                                name, op, id_v, move_v, x_v, y_v, ex_v, ey_v);
                // Comment and blank lines never yield all eight columns
                if (count == 8) begin
                    entry.name  = name;
                    entry.op    = op;
                    entry.id    = id_v;
                    entry.move  = move_t'(move_v);
                    entry.x     = result_t'(x_v);
                    entry.y     = result_t'(y_v);
                    entry.exp_x = result_t'(ex_v);
                    entry.exp_y = result_t'(ey_v);
                    trace.push_back(entry);
                end
            end
            $fclose(fd);
        end
        if (trace.size() == 0) begin
            other_errors++;
            $display("The trace holds no test steps");
        end
    endtask

    task automatic check_draw(input trace_entry_t t);
        pixel_t exp_pix;
        int     k;
        if (pixel_log.size() != NUM_PIXELS) begin
            value_errors++;
            $display("** Error %0s: pixel count expected %0d actual %0d",
                     t.name, NUM_PIXELS, pixel_log.size());
        end
        for (k = 0; k < NUM_PIXELS && k < pixel_log.size(); k++) begin
            // Row by row from the top-left corner
            exp_pix = '{plot: 1'b1, colour: `COLOUR_ANT,
                        x: x_coord_t'(t.exp_x + k % `ANT_WIDTH),
                        y: y_coord_t'(t.exp_y + k / `ANT_WIDTH)};
            if (pixel_log[k] != exp_pix) begin
                value_errors++;
                $display("** Error %0s: pixel %0d expected %h actual %h",
                         t.name, k, exp_pix, pixel_log[k]);
            end
        end
        if (write_count != 0) begin
            value_errors++;
            $display("** Error %0s: memory writes expected 0 actual %0d", t.name, write_count);
        end
    endtask

    task automatic check_update(input trace_entry_t t);
        mem_addr_t x_addr;
        mem_addr_t y_addr;
        x_addr = `ANT_X_BASE + t.id;
        y_addr = `ANT_Y_BASE + t.id;
        if (pixel_log.size() != 0) begin
            value_errors++;
            $display("** Error %0s: draw commands expected 0 actual %0d",
                     t.name, pixel_log.size());
        end
        if (write_count != 2) begin
            value_errors++;
            $display("** Error %0s: memory writes expected 2 actual %0d", t.name, write_count);
        end
        if (mem[x_addr] != t.exp_x) begin
            value_errors++;
            $display("** Error %0s: x expected %0d actual %0d", t.name, t.exp_x, mem[x_addr]);
        end
        if (mem[y_addr] != t.exp_y) begin
            value_errors++;
            $display("** Error %0s: y expected %0d actual %0d", t.name, t.exp_y, mem[y_addr]);
        end
    endtask

    task automatic run_job(input trace_entry_t t);
        mem[`ANT_X_BASE + t.id] = t.x;
        mem[`ANT_Y_BASE + t.id] = t.y;
        pixel_log.delete();
        write_count  = 0;
        id           = t.id;
        move         = t.move;
        start_update = (t.op == "U" || t.op == "B" || t.op == "I");
        start_draw   = (t.op == "D" || t.op == "B");
        @(negedge clock);
        start_update = 1'b0;
        start_draw   = 1'b0;
        if (!busy) begin
            other_errors++;
            $display("%0s: busy did not rise after the start pulse", t.name);
        end
        if (t.op == "I") begin
            repeat (3) @(negedge clock);
            start_draw = 1'b1;
            @(negedge clock);
            start_draw = 1'b0;
        end
        while (busy) @(negedge clock);
        if (t.op == "B" || t.op == "I") begin
            repeat (2) @(negedge clock);
            if (busy) begin
                other_errors++;
                $display("%0s: a second job ran after the update job", t.name);
            end
        end
        if (t.op == "D") begin
            check_draw(t);
        end else begin
            check_update(t);
        end
    endtask

    initial begin
        int a;
        int i;
        resetn       = 1'b0;
        start_draw   = 1'b0;
        start_update = 1'b0;
        id           = '0;
        move         = '0;
        finished_dp  = 1'b0;
        result_dp    = '0;
        value_errors = 0;
        other_errors = 0;
        write_count  = 0;
        cycle_count  = 0;
        cycle_limit  = 0;
        lfsr         = 32'h1297;
        for (a = 0; a < MEM_WORDS; a++) begin
            mem[a] = {a[7:0], ~a[7:0]};
        end
        load_trace();
        cycle_limit = trace.size() * JOB_CYCLES + 50;
        repeat (3) @(negedge clock);
        resetn = 1'b1;
        @(negedge clock);
        if (start_dp || busy || instruction_dp != '0) begin
            other_errors++;
            $display("Outputs were not cleared by reset");
        end
        for (i = 0; i < trace.size(); i++) begin
            run_job(trace[i]);
        end
        $display("Errors: %0d value mismatches, %0d other failures, %0d tests",
                 value_errors, other_errors, trace.size());
        if (value_errors + other_errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

/* tb/ant_engine_trace.txt */
# name op id(hex) move(hex: left right up down) x y exp_x exp_y
# op: D draw, U update, B both starts together, I draw start while busy; draw expects the corner
draw_mid     D 03 0  50  40  49  39
draw_corner  D 10 0   1   1   0   0
draw_edge    D 3f 0 158 118 157 117
upd_left     U 01 8  50  40  49  40
upd_right    U 01 4  50  40  51  40
upd_up       U 02 2  50  40  50  39
upd_down     U 02 1  50  40  50  41
upd_diag_ul  U 05 a  20  30  19  29
upd_diag_rd  U 05 5  20  30  21  31
upd_lr       U 06 c  70  60  70  60
upd_ud       U 06 3  70  60  70  60
upd_all      U 07 f  10  10  10  10
upd_none     U 07 0  33  44  33  44
edge_left    U 08 8   1  60   1  60
edge_right   U 08 4 158  60 158  60
edge_up      U 09 2  60   1  60   1
edge_down    U 09 1  60 118  60 118
near_left    U 0a 8   2  60   1  60
near_right   U 0a 4 157  60 158  60
lr_at_left   U 0b c   1  50   2  50
lr_at_right  U 0b c 158  50 158  50
ud_at_top    U 0c 3  50   1  50   2
ud_at_bottom U 0c 3  50 118  50 118
both_start   B 0d 4  80  80  81  80
busy_draw    I 0e 1  80  80  80  81
draw_after   D 0e 0  80  81  79  80

/* build.f */
+incdir+rtl
rtl/ant_pkg.sv
rtl/dp_issuer.sv
rtl/ant_draw.sv
rtl/ant_update.sv
rtl/ant_engine.sv
tb/ant_engine_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the ant engine testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -f build.f \
    --top-module ant_engine_tb -o ant_engine_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/ant_engine_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qx "Test OK" "$LOG"; then
    exit 0
fi
exit 1
